// ==== csr_unit_testdata.txt ====
# test kind a b expected flag next
# I: a=instruction b=rs1 value flag=illegal; W/R: a=paddr b=pwdata flag=pslverr
1 I 340290F3 12345678 00000000 0 0
1 I 34032173 0000F00F 12345678 0 0
1 I 3403B1F3 FF000000 1234F67F 0 0
1 I 340AD273 DEADBEEF 0034F67F 0 0
1 I 340562F3 00000000 00000015 0 0
1 I 3401F373 00000000 0000001F 0 0
1 R 00000D00 00000000 0000001C 0 0
2 I 340020F3 FFFFFFFF 0000001C 0 0
2 I 34007173 00000000 0000001C 0 0
2 I 300291F3 FFFFFFFF 00000000 0 0
2 I 30002273 00000000 00000088 0 0
2 I 305290F3 FFFFFFFF 00000000 0 0
2 R 00000C14 00000000 FFFFFFFD 0 0
2 I 341290F3 12345677 00000000 0 0
2 R 00000D04 00000000 12345674 0 0
3 I 7C0290F3 000000AA 00000000 1 0
3 I 34029093 000000BB 00000000 1 0
3 I 301290F3 00000000 00000000 1 0
3 I 30102173 00000000 40000100 0 0
3 R 00000D00 00000000 0000001C 0 0
4 I 342290F3 00000001 00000000 0 0
4 I 34232173 00000010 00000001 0 0
4 I 3420F1F3 00000000 00000011 0 0
4 I 342FD273 00000000 00000010 0 0
4 I 342022F3 00000000 0000001F 0 0
5 W 00000D00 CAFEF00D 00000000 0 0
5 R 00000D00 00000000 CAFEF00D 0 0
5 W 00003C50 00000005 00000000 1 0
5 R 00001F00 00000000 00000000 1 0
5 R 00003C50 00000000 00000000 0 0
5 I 340293F3 11111111 CAFEF00D 0 1
5 W 00000D00 22222222 00000000 0 0
5 R 00000D00 00000000 22222222 0 0

// ==== verilog.f ====
riscv_pkg.sv
csr_unit_pkg.sv
csr_decode.sv
csr_alu.sv
csr_file.sv
csr_apb.sv
csr_unit_top.sv
csr_unit_chk.sv
csr_unit_scoreboard.sv
csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - riscv_pkg.sv
  - csr_unit_pkg.sv
  - csr_decode.sv
  - csr_alu.sv
  - csr_file.sv
  - csr_apb.sv
  - csr_unit_top.sv
  - target: test
    files:
      - csr_unit_chk.sv
      - csr_unit_scoreboard.sv
      - csr_unit_tb.sv

// ==== csr_unit_tb.sv ====
`timescale 1ns/100ps

module csr_unit_tb;
    import csr_unit_pkg::*;

    // one line of the data file
    typedef struct packed {
        int          test;
        logic [7:0]  kind;       // I, W or R
        logic [31:0] a;          // instruction or paddr
        logic [31:0] b;          // rs1 value or pwdata
        logic [31:0] exp;        // rd value or prdata
        logic        flag;       // illegal or pslverr
        logic        with_next;  // issue together with the next record
    } rec_t;

    logic     clk;
    logic     rst_n;
    csr_req_t req;
    logic     req_valid;
    logic     req_ready;
    csr_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    rec_t recs[$];
    int   cycles = 0;
    int   limit = 0;

    csr_unit_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .rsp      (rsp),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    csr_unit_scoreboard sb (
        .clk      (clk),
        .rst_n    (rst_n),
        .rsp      (rsp),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : ready_gen
        int seed;
        seed = 78;
        void'($urandom(seed));
        forever begin
            @(posedge clk);
            #1;
            rsp_ready = ($urandom % 4) != 0;  // drop about one cycle in four
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // ******************************
    // stimulus tasks
    // ******************************

    task automatic load_records();
        int          fd;
        int          n;
        int          test;
        int          flag;
        int          nxt;
        string       line;
        string       kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        rec_t        r;
        fd = $fopen("csr_unit_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open csr_unit_testdata.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %s %h %h %h %d %d", test, kind, a, b, e, flag, nxt);
                    if (n == 7) begin
                        r.test      = test;
                        r.kind      = kind[0];
                        r.a         = a;
                        r.b         = b;
                        r.exp       = e;
                        r.flag      = flag[0];
                        r.with_next = nxt[0];
                        recs.push_back(r);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue_instr(rec_t r);
        csr_rsp_t e;
        e.rd_idx  = r.a[11:7];  // rd field of the instruction word
        e.rd_val  = r.exp;
        e.illegal = r.flag;
        sb.exp_rsp.push_back(e);
        req.instr   = r.a;
        req.rs1_val = r.b;
        req_valid   = 1'b1;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic apb_access(rec_t r);
        apb_rsp_t e;
        e.prdata  = r.exp;
        e.pready  = 1'b1;
        e.pslverr = r.flag;
        sb.exp_apb.push_back(e);
        apb_req.paddr   = r.a[15:0];
        apb_req.pwrite  = (r.kind == "W");
        apb_req.pwdata  = r.b;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        do @(negedge clk); while (!apb_rsp.pready);
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    // wait until every expected response has been seen
    task automatic drain();
        while (sb.exp_rsp.size() > 0 || sb.exp_apb.size() > 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin
        int   i;
        int   cur_test;
        rec_t r;
        rst_n     = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        apb_req   = '0;
        load_records();
        limit = 10 * recs.size() + 100;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        if (recs.size() > 0) begin
            cur_test = recs[0].test;
            i = 0;
            while (i < recs.size()) begin
                r = recs[i];
                if (r.test != cur_test) begin
                    drain();
                    sb.end_test(cur_test);
                    cur_test = r.test;
                end
                if (r.kind == "I" && r.with_next && i + 1 < recs.size()) begin
                    drain();  // stage 2 empty, so the write lands in the access phase
                    fork
                        issue_instr(r);
                        apb_access(recs[i + 1]);
                    join
                    i = i + 1;
                end else if (r.kind == "I") begin
                    issue_instr(r);
                end else begin
                    drain();
                    apb_access(r);
                end
                i = i + 1;
            end
            drain();
            sb.end_test(cur_test);
        end else begin
            $display("no test records were read from csr_unit_testdata.txt");
        end
        sb.summary(uut.u_chk.n_errors);
        if (sb.n_fail == 0 && sb.n_pass > 0 && uut.u_chk.n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== csr_unit_scoreboard.sv ====
`timescale 1ns/100ps

module csr_unit_scoreboard (
    input logic                   clk,
    input logic                   rst_n,
    input csr_unit_pkg::csr_rsp_t rsp,
    input logic                   rsp_valid,
    input logic                   rsp_ready,
    input csr_unit_pkg::apb_req_t apb_req,
    input csr_unit_pkg::apb_rsp_t apb_rsp
);
    import csr_unit_pkg::*;

    csr_rsp_t exp_rsp[$];
    apb_rsp_t exp_apb[$];
    int       test_errs = 0;
    int       n_pass = 0;
    int       n_fail = 0;
    int       n_checks = 0;

    always @(posedge clk) begin : watch_rsp
        csr_rsp_t e;
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_rsp.size() == 0) begin
                $display("a response came back at %0t ns with no instruction waiting", $time);
                test_errs++;
            end else begin
                e = exp_rsp.pop_front();
                n_checks++;
                if (rsp !== e) begin
                    $display("ERR %0t: rsp rd=%0d val=%h illegal=%b, expected rd=%0d val=%h illegal=%b",
                             $time, rsp.rd_idx, rsp.rd_val, rsp.illegal,
                             e.rd_idx, e.rd_val, e.illegal);
                    test_errs++;
                end
            end
        end
    end

    // access phase completes on pready
    always @(posedge clk) begin : watch_apb
        apb_rsp_t e;
        if (rst_n && apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            if (exp_apb.size() == 0) begin
                $display("an APB access completed at %0t ns that was never started", $time);
                test_errs++;
            end else begin
                e = exp_apb.pop_front();
                n_checks++;
                if (apb_rsp.pslverr !== e.pslverr
                    || (!apb_req.pwrite && apb_rsp.prdata !== e.prdata)) begin
                    $display("ERR %0t: apb %h prdata=%h pslverr=%b, expected prdata=%h pslverr=%b",
                             $time, apb_req.paddr, apb_rsp.prdata, apb_rsp.pslverr,
                             e.prdata, e.pslverr);
                    test_errs++;
                end
            end
        end
    end

    task automatic end_test(int num);
        if (test_errs == 0) begin
            n_pass++;
            $display("test %0d passed", num);
        end else begin
            n_fail++;
            $display("test %0d failed with %0d errors", num, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic summary(int assert_errs);
        $display("tests passed %0d, failed %0d, checks %0d, assertion failures %0d",
                 n_pass, n_fail, n_checks, assert_errs);
    endtask

endmodule

// ==== csr_unit_chk.sv ====
`timescale 1ns/100ps

module csr_unit_chk (
    input logic                   clk,
    input logic                   rst_n,
    input csr_unit_pkg::csr_req_t req,
    input logic                   req_valid,
    input logic                   req_ready,
    input csr_unit_pkg::csr_rsp_t rsp,
    input logic                   rsp_valid,
    input logic                   rsp_ready,
    input csr_unit_pkg::apb_req_t apb_req,
    input csr_unit_pkg::apb_rsp_t apb_rsp
);
    int n_errors = 0;

    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
    else begin
        $error("issue request changed before it was accepted");
        n_errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
        $error("response changed while the core was stalling it");
        n_errors++;
    end

    // address and data hold from setup to completion
    assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=>
        apb_req.psel && $stable(apb_req.paddr) && $stable(apb_req.pwrite)
        && $stable(apb_req.pwdata))
    else begin
        $error("APB request changed before the transfer completed");
        n_errors++;
    end

    assert property (@(posedge clk) !rst_n |-> !rsp_valid)
    else begin
        $error("rsp_valid high during reset");
        n_errors++;
    end

endmodule

bind csr_unit_top csr_unit_chk u_chk (.*);

// ==== csr_unit_top.sv ====
`timescale 1ns/100ps

module csr_unit_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  csr_unit_pkg::csr_req_t req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output csr_unit_pkg::csr_rsp_t rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    input  csr_unit_pkg::apb_req_t apb_req,
    output csr_unit_pkg::apb_rsp_t apb_rsp
);
    import csr_unit_pkg::*;

    csr_op_t     op;
    logic        op_valid;
    logic        advance;
    logic [31:0] i_rdata;
    logic [31:0] rd_val;
    logic [31:0] wdata;
    logic        wen;
    logic        i_wen;
    csr_addr_t   h_addr;
    logic        h_wen;
    logic [31:0] h_wdata;
    logic [31:0] h_rdata;

    // stage 2 takes stage 1 when empty or draining this cycle
    assign advance = op_valid && (!rsp_valid || rsp_ready);
    assign i_wen   = wen && advance;  // write as the op leaves stage 1

    csr_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .advance  (advance),
        .op       (op),
        .op_valid (op_valid)
    );

    csr_alu u_alu (
        .op       (op),
        .csr_rdata(i_rdata),
        .rd_val   (rd_val),
        .wdata    (wdata),
        .wen      (wen)
    );

    csr_file u_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_addr (op.addr),
        .i_rdata(i_rdata),
        .i_wen  (i_wen),
        .i_wdata(wdata),
        .h_addr (h_addr),
        .h_rdata(h_rdata),
        .h_wen  (h_wen),
        .h_wdata(h_wdata)
    );

    csr_apb u_apb (
        .clk         (clk),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .h_addr      (h_addr),
        .h_wen       (h_wen),
        .h_wdata     (h_wdata),
        .h_rdata     (h_rdata),
        .inst_wr_busy(i_wen)
    );

    // ******************************
    // stage 2 response register
    // ******************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (advance) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            rsp.rd_idx  <= op.rd_idx;
            rsp.rd_val  <= op.legal ? rd_val : 32'h0000_0000;  // illegal returns zero
            rsp.illegal <= !op.legal;
        end
    end

endmodule

// ==== csr_apb.sv ====
`timescale 1ns/100ps

module csr_apb (
    input  logic                    clk,
    input  logic                    rst_n,
    input  csr_unit_pkg::apb_req_t  apb_req,
    output csr_unit_pkg::apb_rsp_t  apb_rsp,
    output csr_unit_pkg::csr_addr_t h_addr,
    output logic                    h_wen,
    output logic [31:0]             h_wdata,
    input  logic [31:0]             h_rdata,
    input  logic                    inst_wr_busy
);
    import csr_unit_pkg::*;

    logic access;
    logic done_q;
    logic bad_access;
    logic complete;

    assign h_addr = apb_req.paddr[13:2];  // word address

    // done_q keeps a held access phase from completing twice
    assign access     = apb_req.psel && apb_req.penable && !done_q;
    assign bad_access = !csr_known(h_addr) || (apb_req.pwrite && !csr_writable(h_addr));
    assign complete   = access && !inst_wr_busy;  // wait out instruction writes

    assign h_wen   = complete && apb_req.pwrite && !bad_access;
    assign h_wdata = apb_req.pwdata;

    assign apb_rsp.prdata  = h_rdata;
    assign apb_rsp.pready  = complete;
    assign apb_rsp.pslverr = complete && bad_access;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (complete) begin
            done_q <= 1'b1;
        end else if (!apb_req.penable) begin
            done_q <= 1'b0;
        end
    end

endmodule

// ==== csr_file.sv ====
`timescale 1ns/100ps

module csr_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  csr_unit_pkg::csr_addr_t i_addr,
    output logic [31:0]             i_rdata,
    input  logic                    i_wen,
    input  logic [31:0]             i_wdata,
    input  csr_unit_pkg::csr_addr_t h_addr,
    output logic [31:0]             h_rdata,
    input  logic                    h_wen,
    input  logic [31:0]             h_wdata
);
    import csr_unit_pkg::*;

    csr_regs_t   regs;
    logic        wen;
    csr_addr_t   waddr;
    logic [31:0] wdata;

    function automatic logic [31:0] read_csr(csr_regs_t r, csr_addr_t addr);
        case (addr)
            csr_mstatus_c:  read_csr = r.mstatus;
            csr_misa_c:     read_csr = misa_value_c;
            csr_mtvec_c:    read_csr = r.mtvec;
            csr_mscratch_c: read_csr = r.mscratch;
            csr_mepc_c:     read_csr = r.mepc;
            csr_mcause_c:   read_csr = r.mcause;
            csr_mhartid_c:  read_csr = mhartid_value_c;
            default:        read_csr = 32'h0000_0000;
        endcase
    endfunction

    // only the bits in mask take the new value
    function automatic logic [31:0] merge(
        logic [31:0] old_val,
        logic [31:0] new_val,
        logic [31:0] mask
    );
        merge = (new_val & mask) | (old_val & ~mask);
    endfunction

    assign i_rdata = read_csr(regs, i_addr);
    assign h_rdata = read_csr(regs, h_addr);

    // ******************************
    // shared write port
    // ******************************

    assign wen   = i_wen || h_wen;
    assign waddr = i_wen ? i_addr : h_addr;  // instruction side wins
    assign wdata = i_wen ? i_wdata : h_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= csr_regs_rst_c;
        end else if (wen) begin
            case (waddr)
                csr_mstatus_c:  regs.mstatus  <= merge(regs.mstatus, wdata, mstatus_mask_c);
                csr_mtvec_c:    regs.mtvec    <= merge(regs.mtvec, wdata, mtvec_mask_c);
                csr_mscratch_c: regs.mscratch <= wdata;
                csr_mepc_c:     regs.mepc     <= merge(regs.mepc, wdata, mepc_mask_c);
                csr_mcause_c:   regs.mcause   <= wdata;
                default:        ;  // read-only or unmapped
            endcase
        end
    end

endmodule

// ==== csr_alu.sv ====
`timescale 1ns/100ps

module csr_alu (
    input  csr_unit_pkg::csr_op_t op,
    input  logic [31:0]           csr_rdata,
    output logic [31:0]           rd_val,
    output logic [31:0]           wdata,
    output logic                  wen
);
    import riscv_pkg::*;

    logic [31:0] operand;

    // immediate forms take the zero-extended uimm
    assign operand = op.funct3[f3_imm_bit_c] ? {27'b0, op.uimm} : op.rs1_val;

    assign rd_val = csr_rdata;  // rd always gets the old value
    assign wen    = op.legal && op.wr_intent;

    always_comb begin
        case (op.funct3)
            f3_csrrw, f3_csrrwi: wdata = operand;
            f3_csrrs, f3_csrrsi: wdata = csr_rdata | operand;
            f3_csrrc, f3_csrrci: wdata = csr_rdata & ~operand;
            default:             wdata = csr_rdata;  // wen is low here
        endcase
    end

endmodule

// ==== csr_decode.sv ====
`timescale 1ns/100ps

module csr_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  csr_unit_pkg::csr_req_t req,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  logic                   advance,
    output csr_unit_pkg::csr_op_t  op,
    output logic                   op_valid
);
    import riscv_pkg::*;
    import csr_unit_pkg::*;

    instr_u  instr;
    logic    is_system;
    logic    f3_known;
    logic    wr_intent;
    logic    accept;
    csr_op_t op_d;

    assign instr     = req.instr;
    assign is_system = (instr.i.opcode == op_system_c);
    assign req_ready = !op_valid || advance;  // empty or moving on
    assign accept    = req_valid && req_ready;

    always_comb begin
        case (instr.i.funct3)
            f3_csrrw, f3_csrrs, f3_csrrc,
            f3_csrrwi, f3_csrrsi, f3_csrrci: f3_known = 1'b1;
            default:                         f3_known = 1'b0;
        endcase
    end

    // set/clear with x0 or zimm=0 only reads
    always_comb begin
        case (instr.i.funct3)
            f3_csrrw, f3_csrrwi: wr_intent = 1'b1;
            default:             wr_intent = (instr.c.uimm != 5'd0);
        endcase
    end

    always_comb begin
        op_d.funct3    = funct3_e'(instr.i.funct3);
        op_d.addr      = instr.c.csr;
        op_d.uimm      = instr.c.uimm;
        op_d.rs1_val   = req.rs1_val;
        op_d.rd_idx    = instr.i.rd;
        op_d.wr_intent = wr_intent;
        op_d.legal     = is_system && f3_known && csr_known(instr.c.csr)
                         && (!wr_intent || csr_writable(instr.c.csr));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else if (accept) begin
            op_valid <= 1'b1;
        end else if (advance) begin
            op_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op <= op_d;
        end
    end

endmodule

// ==== csr_unit_pkg.sv ====
package csr_unit_pkg;

    typedef logic [11:0] csr_addr_t;

    // ******************************
    // csr map
    // ******************************

    localparam csr_addr_t csr_mstatus_c  = 12'h300;
    localparam csr_addr_t csr_misa_c     = 12'h301;
    localparam csr_addr_t csr_mtvec_c    = 12'h305;
    localparam csr_addr_t csr_mscratch_c = 12'h340;
    localparam csr_addr_t csr_mepc_c     = 12'h341;
    localparam csr_addr_t csr_mcause_c   = 12'h342;
    localparam csr_addr_t csr_mhartid_c  = 12'hF14;

    localparam logic [31:0] mstatus_mask_c  = 32'h0000_0088;  // mie, mpie
    localparam logic [31:0] mtvec_mask_c    = 32'hFFFF_FFFD;
    localparam logic [31:0] mepc_mask_c     = 32'hFFFF_FFFC;  // 4-byte aligned
    localparam logic [31:0] misa_value_c    = 32'h4000_0100;  // mxl=1, I
    localparam logic [31:0] mhartid_value_c = 32'h0000_0000;

    typedef struct packed {
        logic [31:0] mstatus;
        logic [31:0] mtvec;
        logic [31:0] mscratch;
        logic [31:0] mepc;
        logic [31:0] mcause;
    } csr_regs_t;

    localparam csr_regs_t csr_regs_rst_c = '{default: 32'h0000_0000};

    function automatic logic csr_known(csr_addr_t addr);
        case (addr)
            csr_mstatus_c, csr_misa_c, csr_mtvec_c, csr_mscratch_c,
            csr_mepc_c, csr_mcause_c, csr_mhartid_c: csr_known = 1'b1;
            default:                                  csr_known = 1'b0;
        endcase
    endfunction

    function automatic logic csr_writable(csr_addr_t addr);
        csr_writable = csr_known(addr) && (addr != csr_misa_c) && (addr != csr_mhartid_c);
    endfunction

    // ******************************
    // port structs
    // ******************************

    typedef struct packed {
        riscv_pkg::instr_u instr;
        logic [31:0]       rs1_val;
    } csr_req_t;

    typedef struct packed {
        riscv_pkg::funct3_e funct3;
        csr_addr_t          addr;
        logic [4:0]         uimm;
        logic [31:0]        rs1_val;
        logic [4:0]         rd_idx;
        logic               wr_intent;
        logic               legal;
    } csr_op_t;

    typedef struct packed {
        logic [4:0]  rd_idx;
        logic [31:0] rd_val;
        logic        illegal;
    } csr_rsp_t;

    typedef struct packed {
        logic [15:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// ==== riscv_pkg.sv ====
package riscv_pkg;

    // ******************************
    // opcodes
    // ******************************

    localparam logic [6:0] op_system_c = 7'b11_100_11;

    // ******************************
    // zicsr funct3 codes
    // ******************************

    typedef enum logic [2:0] {
        f3_csrrw  = 3'b001,
        f3_csrrs  = 3'b010,
        f3_csrrc  = 3'b011,
        f3_csrrwi = 3'b101,
        f3_csrrsi = 3'b110,
        f3_csrrci = 3'b111
    } funct3_e;

    localparam int f3_imm_bit_c = 2;  // set for the uimm forms

    // ******************************
    // instruction word
    // ******************************

    // base I-type layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    // same bits seen as a CSR access
    typedef struct packed {
        logic [11:0] csr;   // csr address in imm12
        logic [4:0]  uimm;  // rs1 index or zimm
        funct3_e     funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_instr_t;

    typedef union packed {
        itype_t     i;
        csr_instr_t c;
    } instr_u;

endpackage
